// File: design/dmem_cmd_queue.sv
//----------------------------------------------------------------------
// data memory command queue: circular buffer with one slot per thread,
// entry parity added on write, show-ahead head for the issue logic
//----------------------------------------------------------------------
`default_nettype none

module dmem_cmd_queue (
	input logic gclk,
	input logic rst,
	input logic we,	// push from the input register
	input memif_pkg::cmd_entry_t din,
	input logic pop,	// request sent to memory
	output memif_pkg::cmd_entry_t head,
	output logic empty
);
	import memif_pkg::*;

	logic [tid_w-1:0] head_ptr;	// oldest entry
	logic [tid_w-1:0] tail_ptr;	// next free slot
	logic last_rd;	// last pointer move was a pop
	logic full;
	cmd_entry_t wr_entry;	// din with parity filled in

	cmd_entry_t q_mem [nthread];	// small enough for distributed ram

	//------------------------------------------------------------------
	// write side
	//------------------------------------------------------------------
	always_comb begin
		wr_entry = din;
		// even parity so the whole entry xors to 0
		wr_entry.parity = ^{din.tid, din.cmd, din.ret_index};
	end

	always_ff @(posedge gclk) begin
		if (we)
			q_mem[tail_ptr] <= wr_entry;
	end

	always_ff @(posedge gclk) begin
		if (rst)
			tail_ptr <= '0;
		else if (we)
			tail_ptr <= tail_ptr + 1'b1;	// wraps at nthread
	end

	//------------------------------------------------------------------
	// read side
	//------------------------------------------------------------------
	always_ff @(posedge gclk) begin
		if (rst)
			head_ptr <= '0;
		else if (pop)
			head_ptr <= head_ptr + 1'b1;
	end

	// push and pop together only happen with pointers apart,
	// so the push setting wins here
	always_ff @(posedge gclk) begin
		if (rst)
			last_rd <= 1'b1;	// starts empty
		else if (we)
			last_rd <= 1'b0;
		else if (pop)
			last_rd <= 1'b1;
	end

	// equal pointers are either empty or full
	assign empty = (head_ptr == tail_ptr) ? last_rd : 1'b0;
	assign full = (head_ptr == tail_ptr) && !last_rd;

	assign head = q_mem[head_ptr];	// show-ahead, no output register

	//------------------------------------------------------------------
	// checks
	//------------------------------------------------------------------
	// IU keeps one command per thread in flight, so nthread slots do
	a_no_overflow: assert property (
		@(posedge gclk) disable iff (rst)
		!(we && full)
	) else $error("dmem queue written while full");

	// issue logic only pops a non-empty queue
	a_no_underflow: assert property (
		@(posedge gclk) disable iff (rst)
		!(pop && empty)
	) else $error("dmem queue popped while empty");

endmodule

`default_nettype wire

// File: design/dmem_if.sv
//----------------------------------------------------------------------
// data memory interface top: IU command register, command queue,
// request issue, status buffer and cache write forwarding
//----------------------------------------------------------------------
`default_nettype none

module dmem_if #(
	parameter int mem_credit = 4	// memory controller request slots
) (
	input logic gclk,
	input logic rst,
	// IU
	input memif_pkg::mem_cmd_t iu_cmd,
	input logic [memif_pkg::tid_w-1:0] iu_tid,	// busy read-back tid
	output memif_pkg::stat_t iu_stat,
	// memory controller
	input memif_pkg::mem_ctrl_t mem_ctrl,
	input memif_pkg::mem_res_t mem_res,
	output memif_pkg::mem_req_t mem_req,
	// data cache
	output memif_pkg::cache_wr_t cache_wr,
	output logic luterr	// queue parity error
);
	import memif_pkg::*;

	mem_cmd_t cmd_r;	// command input register
	cmd_entry_t q_din;
	cmd_entry_t q_head;
	logic q_empty;
	logic q_pop;
	logic par_err;

	//------------------------------------------------------------------
	// IU side
	//------------------------------------------------------------------
	always_ff @(posedge gclk) begin
		cmd_r <= iu_cmd;
		if (rst)
			cmd_r.valid <= 1'b0;
	end

	always_comb begin
		q_din.tid = cmd_r.tid;
		q_din.cmd = cmd_r.cmd;
		q_din.ret_index = cmd_r.ret_index;
		q_din.parity = 1'b0;	// queue computes it
	end

	dmem_cmd_queue u_cmd_queue (
		.gclk (gclk),
		.rst (rst),
		.we (cmd_r.valid),
		.din (q_din),
		.pop (q_pop),
		.head (q_head),
		.empty (q_empty)
	);

	//------------------------------------------------------------------
	// to memory
	//------------------------------------------------------------------
	mem_req_issue #(
		.mem_credit (mem_credit)
	) u_req_issue (
		.gclk (gclk),
		.rst (rst),
		.head (q_head),
		.empty (q_empty),
		.cmd_re (mem_ctrl.cmd_re),
		.pop (q_pop),
		.mem_req (mem_req),
		.par_err (par_err)
	);

	assign luterr = par_err;	// already registered at pop

	// busy on each command, freed by done
	mem_stat_buf u_stat_buf (
		.gclk (gclk),
		.rst (rst),
		.set_tid (cmd_r.tid),
		.set (cmd_r.valid),
		.clr_tid (mem_res.tid),
		.clr (mem_res.done),
		.rd_tid (iu_tid),
		.stat (iu_stat)
	);

	//------------------------------------------------------------------
	// from memory
	//------------------------------------------------------------------
	always_ff @(posedge gclk) begin
		cache_wr.tid <= mem_res.tid;
		cache_wr.index <= mem_res.ret_index;
		cache_wr.data <= mem_res.data;
		if (rst)
			cache_wr.we <= 1'b0;
		else
			cache_wr.we <= mem_res.valid;	// one beat per valid
	end

endmodule

`default_nettype wire

// File: design/mem_req_issue.sv
//----------------------------------------------------------------------
// request issue: credit counter toward the memory controller, queue
// pop, write-enable decode and the registered memory request
//----------------------------------------------------------------------
`default_nettype none

module mem_req_issue #(
	parameter int mem_credit = 4	// requests in flight, 1..15
) (
	input logic gclk,
	input logic rst,
	input memif_pkg::cmd_entry_t head,
	input logic empty,
	input logic cmd_re,	// credit return
	output logic pop,
	output memif_pkg::mem_req_t mem_req,
	output logic par_err
);
	import memif_pkg::*;

	logic [3:0] ccnt;	// credits left
	logic [3:0] ccnt_nxt;
	logic is_wr;	// head command carries write data

	//------------------------------------------------------------------
	// flow control
	//------------------------------------------------------------------
	always_comb begin
		// a credit returned this cycle can be spent right away
		pop = !empty && (ccnt != 4'd0 || cmd_re);
		ccnt_nxt = ccnt;
		if (pop && !cmd_re)
			ccnt_nxt = ccnt - 4'd1;	// spend one
		else if (!pop && cmd_re)
			ccnt_nxt = ccnt + 4'd1;	// one back
	end

	always_ff @(posedge gclk) begin
		if (rst)
			ccnt <= 4'(mem_credit);	// full credit out of reset
		else
			ccnt <= ccnt_nxt;
	end

	//------------------------------------------------------------------
	// request register
	//------------------------------------------------------------------
	assign is_wr = (head.cmd == dcache_wb) || (head.cmd == dtlb_write);

	always_ff @(posedge gclk) begin
		if (pop) begin	// payload holds between requests
			mem_req.tid <= head.tid;
			mem_req.ret_index <= head.ret_index;
			// strip cmd from the stored parity
			mem_req.tid_index_parity <= head.parity ^ (^head.cmd);
		end
		if (rst) begin
			mem_req.valid <= 1'b0;
			mem_req.we <= 1'b0;
			par_err <= 1'b0;
		end else begin
			mem_req.valid <= pop;
			mem_req.we <= pop && is_wr;
			// a good entry xors to 0 including its parity bit
			par_err <= pop && (^head);
		end
	end

	//------------------------------------------------------------------
	// checks
	//------------------------------------------------------------------
	// memory controller never returns more credits than it was given
	a_credit_max: assert property (
		@(posedge gclk) disable iff (rst)
		ccnt <= mem_credit
	) else $error("dmem credit count above %0d", mem_credit);

endmodule

`default_nettype wire

// File: design/mem_stat_buf.sv
//----------------------------------------------------------------------
// per-thread status buffer: busy set by the IU, cleared by memory,
// read back through a register
//----------------------------------------------------------------------
`default_nettype none

module mem_stat_buf (
	input logic gclk,
	input logic rst,
	input logic [memif_pkg::tid_w-1:0] set_tid,	// IU side
	input logic set,
	input logic [memif_pkg::tid_w-1:0] clr_tid,	// memory side
	input logic clr,
	input logic [memif_pkg::tid_w-1:0] rd_tid,
	output memif_pkg::stat_t stat
);
	import memif_pkg::*;

	stat_t stat_mem [nthread];	// busy + parity per thread

	// parity follows busy, so busy=1 with parity=0 flags a bad bit
	localparam stat_t set_val = '{busy: 1'b1, parity: 1'b1};
	localparam stat_t clr_val = '{busy: 1'b0, parity: 1'b0};

	//------------------------------------------------------------------
	// update
	//------------------------------------------------------------------
	always_ff @(posedge gclk) begin
		if (rst) begin
			for (int i = 0; i < nthread; i++)
				stat_mem[i] <= clr_val;	// all threads idle
		end else begin
			if (clr)
				stat_mem[clr_tid] <= clr_val;
			// last write wins, new command beats old done
			if (set)
				stat_mem[set_tid] <= set_val;
		end
	end

	//------------------------------------------------------------------
	// read back
	//------------------------------------------------------------------
	always_ff @(posedge gclk) begin
		if (rst)
			stat <= clr_val;
		else
			stat <= stat_mem[rd_tid];	// sees last edge's update
	end

endmodule

`default_nettype wire

// File: design/memif_pkg.sv
//----------------------------------------------------------------------
// memif package: widths, data memory command codes and the port
// groups shared by the data-side memory interface
//----------------------------------------------------------------------
`default_nettype none

package memif_pkg;

	//------------------------------------------------------------------
	// sizes
	//------------------------------------------------------------------
	localparam int nthread = 8;	// hw threads, one queue slot each
	localparam int tid_w = 3;	// log2(nthread)
	localparam int index_w = 9;	// cache line return index
	localparam int data_w = 64;	// result data per beat

	// data memory commands from the IU
	typedef enum logic [1:0] {
		dcache_ld,	// line fill
		dcache_wb,	// line writeback
		dtlb_write,
		dtlb_read
	} dmem_cmd_t;

	//------------------------------------------------------------------
	// port groups
	//------------------------------------------------------------------
	typedef struct packed {
		logic valid;	// no ready, IU keeps one per thread
		logic [tid_w-1:0] tid;
		dmem_cmd_t cmd;
		logic [index_w-1:0] ret_index;
	} mem_cmd_t;	// 15 bits

	typedef struct packed {
		logic [tid_w-1:0] tid;
		dmem_cmd_t cmd;
		logic [index_w-1:0] ret_index;
		logic parity;	// even parity over the other fields
	} cmd_entry_t;	// 15 bits

	typedef struct packed {
		logic valid;
		logic we;	// writeback or tlb write
		logic [tid_w-1:0] tid;
		logic [index_w-1:0] ret_index;
		logic tid_index_parity;	// parity of tid and ret_index
	} mem_req_t;	// 15 bits

	typedef struct packed {
		logic cmd_re;	// one credit back
	} mem_ctrl_t;

	typedef struct packed {
		logic valid;	// data beat valid
		logic done;	// command finished, frees the thread
		logic [tid_w-1:0] tid;
		logic [index_w-1:0] ret_index;
		logic [data_w-1:0] data;
	} mem_res_t;	// 78 bits

	typedef struct packed {
		logic we;
		logic [tid_w-1:0] tid;
		logic [index_w-1:0] index;
		logic [data_w-1:0] data;
	} cache_wr_t;	// 77 bits

	typedef struct packed {
		logic busy;
		logic parity;	// copy of busy
	} stat_t;

endpackage

`default_nettype wire

// File: dmem_if.f
design/memif_pkg.sv
design/dmem_cmd_queue.sv
design/mem_req_issue.sv
design/mem_stat_buf.sv
design/dmem_if.sv
dv/clk_gen.sv
dv/dmem_if_tb.sv

// File: dv/clk_gen.sv
//----------------------------------------------------------------------
// testbench clock and reset: 20 ns gclk, rst held for 8 rising edges
//----------------------------------------------------------------------
`default_nettype none

module clk_gen (
	output logic gclk,
	output logic rst
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		gclk = 1'b0;
		forever #10 gclk = ~gclk;	// 20 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (8) @(posedge gclk);
		#2 rst = 1'b0;	// off the edge, like the other inputs
	end

endmodule

`default_nettype wire

// File: dv/dmem_if_tb.sv
//----------------------------------------------------------------------
// testbench for the data memory interface: table-driven IU commands,
// memory controller model with credit tracking and scoreboard checks
//----------------------------------------------------------------------
`default_nettype none

module dmem_if_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import memif_pkg::*;

	localparam int credits = 4;
	localparam int nrows = 8;
	localparam int max_cycles = 2000;	// 6 tests, ~300 cycles each at most

	typedef struct packed {
		logic [tid_w-1:0] tid;
		dmem_cmd_t cmd;
		logic [index_w-1:0] ret_index;
		logic [data_w-1:0] data;	// returned on mem_res
	} row_t;

	logic gclk;
	logic rst;
	mem_cmd_t iu_cmd;
	logic [tid_w-1:0] iu_tid;
	stat_t iu_stat;
	mem_ctrl_t mem_ctrl;
	mem_res_t mem_res;
	mem_req_t mem_req;
	cache_wr_t cache_wr;
	logic luterr;

	row_t rows [nrows];	// row i holds tid i
	int exp_q [$];	// scoreboard, row order of expected requests
	logic [tid_w-1:0] rec_tid [$];	// requests still owed a result
	integer seed = 48;
	int cyc = 0;
	int errors = 0;
	int err_mark = 0;	// errors before current test
	int req_cnt = 0;
	int last_req_cyc = 0;
	int m_cred = credits;	// model's view of the DUT credit
	int beats = 0;	// cache write beats seen on cache_wr
	int luterr_hits = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic auto_re = 1'b0;	// credit back the cycle after each request

	clk_gen u_clk_gen (.gclk(gclk), .rst(rst));

	dmem_if #(
		.mem_credit (credits)
	) u_dmem_if (
		.gclk (gclk),
		.rst (rst),
		.iu_cmd (iu_cmd),
		.iu_tid (iu_tid),
		.iu_stat (iu_stat),
		.mem_ctrl (mem_ctrl),
		.mem_res (mem_res),
		.mem_req (mem_req),
		.cache_wr (cache_wr),
		.luterr (luterr)
	);

	//------------------------------------------------------------------
	// helpers
	//------------------------------------------------------------------
	task automatic load_rows();
		rows[0] = '{3'd0, dcache_ld, 9'h011, 64'h0123_4567_89ab_cdef};
		rows[1] = '{3'd1, dcache_wb, 9'h1a2, 64'hfedc_ba98_7654_3210};
		rows[2] = '{3'd2, dtlb_write, 9'h0f3, 64'h5555_aaaa_0f0f_f0f0};
		rows[3] = '{3'd3, dtlb_read, 9'h144, 64'h0000_0000_0000_0001};
		rows[4] = '{3'd4, dcache_ld, 9'h1ff, 64'h8000_0000_0000_0000};
		rows[5] = '{3'd5, dcache_wb, 9'h000, 64'hdead_beef_cafe_f00d};
		rows[6] = '{3'd6, dtlb_read, 9'h0a5, 64'h1357_9bdf_2468_ace0};
		rows[7] = '{3'd7, dtlb_write, 9'h15a, 64'h7777_3333_cccc_1111};
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] got);
		$display("error t=%0t %s exp=%0h got=%0h", $time, name, exp, got);
		errors++;
	endtask

	task automatic report_fault(input string msg);
		$display("t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic step();
		@(posedge gclk);
		#2;	// drive point
	endtask

	task automatic drive_cmd(input int r, output int drv_cyc);
		iu_cmd.valid = 1'b1;
		iu_cmd.tid = rows[r].tid;
		iu_cmd.cmd = rows[r].cmd;
		iu_cmd.ret_index = rows[r].ret_index;
		exp_q.push_back(r);
		drv_cyc = cyc;
		step();
		iu_cmd.valid = 1'b0;	// one cycle pulse
	endtask

	task automatic wait_reqs(input int target, input int limit);
		int n;
		n = 0;
		while (req_cnt < target && n < limit) begin
			step();
			n++;
		end
		if (req_cnt < target)
			report_fault($sformatf("only %0d of %0d requests arrived", req_cnt, target));
	endtask

	task automatic send_result(input logic [tid_w-1:0] t, input logic valid,
			input logic done);
		mem_res.valid = valid;
		mem_res.done = done;
		mem_res.tid = t;
		mem_res.ret_index = rows[t].ret_index;
		mem_res.data = rows[t].data;
		step();
		mem_res.valid = 1'b0;
		mem_res.done = 1'b0;
	endtask

	task automatic answer_all();
		while (rec_tid.size() > 0)
			send_result(rec_tid.pop_front(), 1'b1, 1'b1);
	endtask

	task automatic pulse_re();
		mem_ctrl.cmd_re = 1'b1;
		step();
		mem_ctrl.cmd_re = 1'b0;
		step();
	endtask

	task automatic check_all_idle();
		for (int t = 0; t < nthread; t++) begin
			iu_tid = t[tid_w-1:0];
			step();	// read-back register
			if (iu_stat.busy !== 1'b0)
				report_mismatch($sformatf("iu_stat.busy[%0d]", t), 1'b0, iu_stat.busy);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == err_mark)
			$display("test %0d %s: pass", tests_run, name);
		else begin
			tests_failed++;
			$display("test %0d %s: fail, %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

	//------------------------------------------------------------------
	// memory controller model and running checks
	//------------------------------------------------------------------
	always @(posedge gclk) begin : mc_model
		int r;
		cyc++;
		if (cyc >= max_cycles) begin
			$display("run stopped at cycle %0d, a test did not finish", cyc);
			$display("Test FAILED");
			$finish;
		end
		#1;	// outputs settled, inputs not yet changed
		if (!rst) begin
			if (mem_ctrl.cmd_re)
				m_cred++;	// returned at this edge
			if (mem_req.valid) begin
				if (m_cred == 0)
					report_fault("request sent while the controller had no credit");
				else
					m_cred--;
				req_cnt++;
				last_req_cyc = cyc;
				rec_tid.push_back(mem_req.tid);
				if (exp_q.size() == 0)
					report_fault("request seen with no command waiting for it");
				else begin
					r = exp_q.pop_front();
					if (mem_req.tid !== rows[r].tid)
						report_mismatch("mem_req.tid", rows[r].tid, mem_req.tid);
					if (mem_req.ret_index !== rows[r].ret_index)
						report_mismatch("mem_req.ret_index", rows[r].ret_index,
							mem_req.ret_index);
					// writeback and tlb write carry a write
					if (mem_req.we !== (rows[r].cmd inside {dcache_wb, dtlb_write}))
						report_mismatch("mem_req.we",
							rows[r].cmd inside {dcache_wb, dtlb_write}, mem_req.we);
					if (mem_req.tid_index_parity !== ^{rows[r].tid, rows[r].ret_index})
						report_mismatch("mem_req.tid_index_parity",
							^{rows[r].tid, rows[r].ret_index}, mem_req.tid_index_parity);
				end
			end
			// cache write is mem_res one edge later
			if (cache_wr.we !== mem_res.valid)
				report_mismatch("cache_wr.we", mem_res.valid, cache_wr.we);
			if (cache_wr.we === 1'b1)
				beats++;	// beat forwarded to the cache
			if (mem_res.valid) begin
				if (cache_wr.tid !== mem_res.tid)
					report_mismatch("cache_wr.tid", mem_res.tid, cache_wr.tid);
				if (cache_wr.index !== mem_res.ret_index)
					report_mismatch("cache_wr.index", mem_res.ret_index, cache_wr.index);
				if (cache_wr.data !== mem_res.data)
					report_mismatch("cache_wr.data", mem_res.data, cache_wr.data);
			end
			if (iu_stat.parity !== iu_stat.busy)
				report_mismatch("iu_stat.parity", iu_stat.busy, iu_stat.parity);
			if (luterr !== 1'b0) begin
				luterr_hits++;
				report_mismatch("luterr", 1'b0, luterr);
			end
		end
		#1;
		if (auto_re)
			mem_ctrl.cmd_re = mem_req.valid;	// hand the credit straight back
	end

	//------------------------------------------------------------------
	// test sequence
	//------------------------------------------------------------------
	initial begin
		int c;
		int base;
		int gap;
		iu_cmd = '0;
		iu_tid = '0;
		mem_ctrl = '0;
		mem_res = '0;
		load_rows();
		wait (rst == 1'b0);
		step();

		// reset state
		if (mem_req.valid !== 1'b0)
			report_mismatch("mem_req.valid", 1'b0, mem_req.valid);
		if (cache_wr.we !== 1'b0)
			report_mismatch("cache_wr.we", 1'b0, cache_wr.we);
		if (luterr !== 1'b0)
			report_mismatch("luterr", 1'b0, luterr);
		check_all_idle();
		end_test("reset state");

		// one command at a time, empty queue gives 3 cycle latency
		auto_re = 1'b1;
		for (int i = 0; i < nrows; i++) begin
			gap = $random(seed) & 3;
			repeat (gap) step();
			base = req_cnt;
			drive_cmd(i, c);
			wait_reqs(base + 1, 20);
			if (last_req_cyc != c + 3)
				report_mismatch("request latency", 3, last_req_cyc - c);
		end
		answer_all();
		end_test("issue order and latency");

		// credits, no returns until 4 spent
		repeat (4) step();
		auto_re = 1'b0;
		base = req_cnt;
		for (int i = 0; i < 6; i++)
			drive_cmd(i, c);
		repeat (20) step();
		if (req_cnt - base != credits)
			report_mismatch("requests on initial credit", credits, req_cnt - base);
		pulse_re();
		pulse_re();
		wait_reqs(base + 6, 20);
		repeat (credits) pulse_re();	// refill for later tests
		if (m_cred != credits)
			report_mismatch("model credit", credits, m_cred);
		auto_re = 1'b1;
		answer_all();
		end_test("credit flow control");

		// busy set 2 cycles after the command, clear 1 cycle after done
		iu_tid = rows[6].tid;
		step();
		if (iu_stat.busy !== 1'b0)
			report_mismatch("iu_stat.busy", 1'b0, iu_stat.busy);
		drive_cmd(6, c);
		step();	// set lands now, register lags
		if (iu_stat.busy !== 1'b0)
			report_mismatch("iu_stat.busy", 1'b0, iu_stat.busy);
		step();
		if (iu_stat.busy !== 1'b1)
			report_mismatch("iu_stat.busy", 1'b1, iu_stat.busy);
		for (int i = 0; i < 5; i++) begin
			step();
			if (iu_stat.busy !== 1'b1)
				report_mismatch("iu_stat.busy", 1'b1, iu_stat.busy);
		end
		if (rec_tid.size() == 0)
			report_fault("status command never reached the memory controller");
		else begin
			send_result(rec_tid.pop_front(), 1'b1, 1'b1);
			if (iu_stat.busy !== 1'b1)
				report_mismatch("iu_stat.busy", 1'b1, iu_stat.busy);
			step();
			if (iu_stat.busy !== 1'b0)
				report_mismatch("iu_stat.busy", 1'b0, iu_stat.busy);
		end
		end_test("busy status");

		// result beats with a gap, cache write follows each
		base = req_cnt;
		drive_cmd(3, c);
		drive_cmd(4, c);
		wait_reqs(base + 2, 20);
		gap = beats;
		while (rec_tid.size() > 0) begin
			c = rec_tid.pop_front();
			send_result(c[tid_w-1:0], 1'b1, 1'b0);	// data only
			send_result(c[tid_w-1:0], 1'b0, 1'b0);	// idle, we stays low
			send_result(c[tid_w-1:0], 1'b1, 1'b1);	// last beat
		end
		step();
		if (beats - gap != 4)
			report_mismatch("forwarded beats", 4, beats - gap);
		end_test("result forwarding");

		// reverse order burst, queue fills a little
		base = req_cnt;
		for (int i = nrows - 1; i >= 0; i--) begin
			gap = $random(seed) & 1;
			repeat (gap) step();
			drive_cmd(i, c);
		end
		wait_reqs(base + nrows, 60);
		answer_all();
		repeat (2) step();
		check_all_idle();
		if (luterr_hits != 0)
			report_fault("queue parity error flag raised during the run");
		end_test("burst and parity flag");

		if (exp_q.size() != 0)
			report_fault("commands left that never reached the memory controller");
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire
